// ==== tb.f ====
hdl/synth_pkg.sv
hdl/uart_rx.sv
hdl/midi_decoder.sv
hdl/sample_ctrl.sv
hdl/pulse_gen.sv
hdl/sigma_delta_dac.sv
hdl/synth_top.sv
tb/synth_checker.sv
tb/tb_synth.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the synthesizer testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_synth \
    -f tb.f -o sim_tb_synth
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_synth > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== tb/tb_synth.sv ====
/*
 * Directed testbench for the MIDI pulse synthesizer.
 * Sends serial MIDI bytes into synth_top, keeps a reference model of the
 * voice and compares the samples and DAC bit density with it.
 */

module tb_synth import synth_pkg::*; ();

    localparam int CLKS_PER_BIT = 16;
    localparam int SAMPLE_DIV   = 64;
    localparam int WAIT_LIMIT   = 4 * SAMPLE_DIV;
    localparam longint FULL_SCALE = longint'(1) << SAMPLE_WIDTH;

    logic                           clk = 1'b0;
    logic                           reset;
    logic                           rx;
    logic                           dac_left;
    logic                           dac_right;
    logic signed [SAMPLE_WIDTH-1:0] left_sample;
    logic signed [SAMPLE_WIDTH-1:0] right_sample;

    // Reference voice state.
    logic [6:0]  model_key = 7'd0;
    logic [6:0]  model_vel = 7'd0;
    logic        model_gate = 1'b0;
    logic [6:0]  model_pan = 7'd64;
    logic [13:0] model_bend = 14'd8192;
    logic [15:0] model_phase = 16'd0;
    logic [15:0] lfsr = 16'd11845;

    synth_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .SAMPLE_DIV(SAMPLE_DIV)) synth_top_i (
        .clk         (clk         ),
        .reset       (reset       ),
        .rx          (rx          ),
        .dac_left    (dac_left    ),
        .dac_right   (dac_right   ),
        .left_sample (left_sample ),
        .right_sample(right_sample)
    );

    always #2 clk = ~clk;

    // Taps 16, 14, 13, 11; one step per bit taken.
    function automatic int lfsr_bits(input int n);
        int   value;
        logic fb;
        value = 0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr  = {lfsr[14:0], fb};
            value = (value << 1) | int'(fb);
        end
        return value;
    endfunction

    function automatic logic [15:0] phase_step();
        int offset;
        offset = int'(model_bend) - 8192;
        return 16'(int'(model_key) * 64 + (offset >>> 4));
    endfunction

    function automatic int expected_level(input int amp);
        if (!model_gate) begin
            return 0;
        end
        return model_phase[15] ? -amp : amp;
    endfunction

    // Phase advances once per left strobe.
    always @(negedge clk) begin
        if (!reset && synth_top_i.gen_left_sample) begin
            model_phase = model_phase + phase_step();
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic check(input string name, input longint actual, input longint expected);
        if (actual !== expected) begin
            stop_run($sformatf("Fail at time %0t: %s is %0d, expected %0d",
                               $time, name, actual, expected));
        end
    endtask

    task automatic wait_right_strobe();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                stop_run("No right sample strobe came within the cycle limit.");
            end
        end while (!synth_top_i.gen_right_sample);
    endtask

    // 8N1 frame sent LSB first.
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    // Aligned so the last byte lands mid sample period, away from strobes.
    task automatic send_msg(input int count, input logic [39:0] bytes);
        wait_right_strobe();
        if (count % 2 == 0) begin
            repeat (SAMPLE_DIV / 2) @(posedge clk);
        end
        for (int i = 0; i < count; i++) begin
            send_byte(bytes[8 * (count - 1 - i) +: 8]);
        end
    endtask

    task automatic apply_message(input logic [3:0] cmd, input logic [6:0] d0,
                                 input logic [6:0] d1);
        if (cmd == MIDI_NOTE_ON && d1 != 7'd0) begin
            model_key   = d0;
            model_vel   = d1;
            model_gate  = 1'b1;
            model_phase = 16'd0;
        end else if ((cmd == MIDI_NOTE_ON || cmd == MIDI_NOTE_OFF) && d0 == model_key) begin
            model_gate = 1'b0;
        end else if (cmd == MIDI_CTRL_CHANGE && d0 == MIDI_CC_PAN) begin
            model_pan = d1;
        end else if (cmd == MIDI_PITCH_BEND) begin
            model_bend = {d1, d0};
        end
    endtask

    // Both samples of the next pair are checked one cycle after the right strobe.
    task automatic check_samples();
        wait_right_strobe();
        @(negedge clk);
        check("left_sample", left_sample,
              expected_level(int'(model_vel) * (127 - int'(model_pan)) * 8));
        check("right_sample", right_sample,
              expected_level(int'(model_vel) * int'(model_pan) * 8));
    endtask

    task automatic random_note_on();
        logic [6:0] key;
        logic [6:0] vel;
        key = 7'(24 + lfsr_bits(6));
        vel = 7'(64 + lfsr_bits(6));
        send_msg(3, {8'h95, 1'b0, key, 1'b0, vel});
        apply_message(MIDI_NOTE_ON, key, vel);
    endtask

    task automatic note_on_test();
        random_note_on();
        repeat (200) check_samples();
    endtask

    task automatic running_status_test();
        logic [6:0] key;
        logic [6:0] vel;
        key = 7'(24 + lfsr_bits(6));
        vel = 7'(64 + lfsr_bits(6));
        send_msg(2, {1'b0, key, 1'b0, vel});
        apply_message(MIDI_NOTE_ON, key, vel);
        repeat (20) check_samples();
        // A wrong key keeps the note sounding.
        send_msg(3, {8'h85, 1'b0, key + 7'd1, 8'h40});
        apply_message(MIDI_NOTE_OFF, key + 7'd1, 7'h40);
        repeat (20) check_samples();
        send_msg(3, {8'h85, 1'b0, key, 8'h00});
        apply_message(MIDI_NOTE_OFF, key, 7'd0);
        repeat (4) check_samples();
    endtask

    task automatic pan_test();
        logic [6:0] pans [3];
        pans[0] = 7'd0;
        pans[1] = 7'd127;
        pans[2] = 7'(lfsr_bits(7));
        random_note_on();
        for (int i = 0; i < 3; i++) begin
            send_msg(3, {8'hB2, 8'h0A, 1'b0, pans[i]});
            apply_message(MIDI_CTRL_CHANGE, MIDI_CC_PAN, pans[i]);
            repeat (10) check_samples();
        end
    endtask

    task automatic bend_test();
        logic [13:0] bends [3];
        bends[0] = 14'd0;
        bends[1] = 14'd16383;
        bends[2] = 14'(lfsr_bits(14));
        for (int i = 0; i < 3; i++) begin
            send_msg(3, {8'hE0, 1'b0, bends[i][6:0], 1'b0, bends[i][13:7]});
            apply_message(MIDI_PITCH_BEND, bends[i][6:0], bends[i][13:7]);
            repeat (40) check_samples();
        end
    endtask

    task automatic ignored_bytes_test();
        send_msg(5, {8'hB0, 8'h0A, 8'hF8, 8'hFE, 8'h30});
        apply_message(MIDI_CTRL_CHANGE, MIDI_CC_PAN, 7'h30);
        repeat (10) check_samples();
        // Running status is gone, so pan stays put.
        send_msg(3, {8'hF0, 8'h0A, 8'h7F});
        repeat (10) check_samples();
    endtask

    // Count of ones must match the density rule within one.
    task automatic check_ones(input string name, input int ones, input int level,
                              input int cycles);
        longint target;
        longint scaled;
        target = longint'(cycles) * (longint'(level) + FULL_SCALE / 2);
        scaled = longint'(ones) * FULL_SCALE;
        if (scaled > target + FULL_SCALE || scaled < target - FULL_SCALE) begin
            check(name, ones, target / FULL_SCALE);
        end
    endtask

    // Right window starts one cycle after the left, as right_sample is later.
    task automatic check_density(input int left_level, input int right_level,
                                 input int cycles);
        int left_ones;
        int right_ones;
        left_ones  = 0;
        right_ones = 0;
        for (int i = 0; i <= cycles; i++) begin
            if (i > 0) begin
                @(negedge clk);
                right_ones += int'(dac_right);
            end
            if (i < cycles) begin
                left_ones += int'(dac_left);
            end
        end
        check_ones("dac_left ones", left_ones, left_level, cycles);
        check_ones("dac_right ones", right_ones, right_level, cycles);
    endtask

    task automatic dac_test();
        send_msg(3, {8'h90, 1'b0, model_key, 8'h00});
        apply_message(MIDI_NOTE_ON, model_key, 7'd0);
        repeat (2) check_samples();
        check_density(0, 0, 1024);
        random_note_on();
        check_samples();
        check_density(expected_level(int'(model_vel) * (127 - int'(model_pan)) * 8),
                      expected_level(int'(model_vel) * int'(model_pan) * 8),
                      SAMPLE_DIV);
    endtask

    initial begin
        reset = 1'b1;
        rx    = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check("left_sample", left_sample, 0);
        check("right_sample", right_sample, 0);
        check("dac_left", dac_left, 0);
        check("dac_right", dac_right, 0);
        @(posedge clk);
        reset <= 1'b0;
        note_on_test();
        running_status_test();
        pan_test();
        bend_test();
        ignored_bytes_test();
        dac_test();
        $display("sim passed");
        $finish;
    end

endmodule

// ==== tb/synth_checker.sv ====
/*
 * Concurrent assertions on the strobe timing inside synth_top.
 * Bound into every synth_top instance.
 */

module synth_checker (
    input logic clk,
    input logic reset,
    input logic gen_left_sample,
    input logic gen_right_sample,
    input logic midi_rdy
);

    // Right strobe trails the left one by one cycle.
    right_follows_left: assert property (@(posedge clk) disable iff (reset)
        gen_left_sample |=> gen_right_sample)
        else $error("gen_right_sample missing after gen_left_sample");

    strobes_apart: assert property (@(posedge clk) disable iff (reset)
        !(gen_left_sample && gen_right_sample))
        else $error("gen_left_sample and gen_right_sample high together");

    rdy_single: assert property (@(posedge clk) disable iff (reset)
        midi_rdy |=> !midi_rdy)
        else $error("midi_rdy high for two cycles in a row");

endmodule

bind synth_top synth_checker synth_checker_i (
    .clk             (clk             ),
    .reset           (reset           ),
    .gen_left_sample (gen_left_sample ),
    .gen_right_sample(gen_right_sample),
    .midi_rdy        (midi_rdy        )
);

// ==== hdl/synth_top.sv ====
/*
 * Top level of the one-voice MIDI pulse synthesizer.
 * Serial MIDI in, two sigma-delta bit streams out, with the parallel
 * samples also brought out for a codec. Bit and sample timing are set here.
 */

module synth_top import synth_pkg::*; #(
    parameter int CLKS_PER_BIT = 16,
    parameter int SAMPLE_DIV   = 64
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           rx,
    output logic                           dac_left,
    output logic                           dac_right,
    output logic signed [SAMPLE_WIDTH-1:0] left_sample,
    output logic signed [SAMPLE_WIDTH-1:0] right_sample
);

    logic          data_received;
    logic [7:0]    data;
    logic          midi_rdy;
    logic [3:0]    midi_cmd;
    logic [3:0]    midi_ch;   // Reserved for channel filtering.
    midi_payload_u midi_payload;
    logic          gen_left_sample;
    logic          gen_right_sample;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_i (
        .clk          (clk          ),
        .reset        (reset        ),
        .rx           (rx           ),
        .data_received(data_received),
        .data         (data         )
    );

    midi_decoder midi_decoder_i (
        .clk          (clk          ),
        .reset        (reset        ),
        .data_received(data_received),
        .data         (data         ),
        .midi_rdy     (midi_rdy     ),
        .midi_cmd     (midi_cmd     ),
        .midi_ch      (midi_ch      ),
        .midi_payload (midi_payload )
    );

    sample_ctrl #(.SAMPLE_DIV(SAMPLE_DIV)) sample_ctrl_i (
        .clk             (clk             ),
        .reset           (reset           ),
        .gen_left_sample (gen_left_sample ),
        .gen_right_sample(gen_right_sample)
    );

    pulse_gen pulse_gen_i (
        .clk             (clk             ),
        .reset           (reset           ),
        .gen_left_sample (gen_left_sample ),
        .gen_right_sample(gen_right_sample),
        .midi_rdy        (midi_rdy        ),
        .midi_cmd        (midi_cmd        ),
        .midi_payload    (midi_payload    ),
        .left_sample     (left_sample     ),
        .right_sample    (right_sample    )
    );

    sigma_delta_dac #(.WIDTH(SAMPLE_WIDTH)) left_dac (
        .clk  (clk        ),
        .reset(reset      ),
        .din  (left_sample),
        .dout (dac_left   )
    );

    sigma_delta_dac #(.WIDTH(SAMPLE_WIDTH)) right_dac (
        .clk  (clk         ),
        .reset(reset       ),
        .din  (right_sample),
        .dout (dac_right   )
    );

endmodule

// ==== hdl/sigma_delta_dac.sv ====
/*
 * First-order sigma-delta modulator.
 * The signed input is moved to offset binary and added into an
 * accumulator every clock; the carry out is the 1-bit output stream,
 * so the density of ones tracks the input level.
 */

module sigma_delta_dac import synth_pkg::*; #(
    parameter int WIDTH = SAMPLE_WIDTH
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic signed [WIDTH-1:0] din,
    output logic                    dout
);

    logic [WIDTH-1:0] accum;
    logic [WIDTH-1:0] offset;
    logic [WIDTH:0]   sum;

    // Flipping the sign bit maps zero to mid-scale.
    assign offset = {~din[WIDTH-1], din[WIDTH-2:0]};
    assign sum    = {1'b0, accum} + {1'b0, offset};

    always_ff @(posedge clk) begin
        if (reset) begin
            accum <= '0;
            dout  <= 1'b0;
        end else begin
            accum <= sum[WIDTH-1:0];
            dout  <= sum[WIDTH];
        end
    end

endmodule

// ==== hdl/pulse_gen.sv ====
/*
 * One-voice square-wave generator.
 * Follows note on/off, pitch bend and the pan controller from the MIDI
 * decoder, and produces signed left and right samples on the strobes
 * from the sample timer.
 */

module pulse_gen import synth_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           gen_left_sample,
    input  logic                           gen_right_sample,
    input  logic                           midi_rdy,
    input  logic [3:0]                     midi_cmd,
    input  midi_payload_u                  midi_payload,
    output logic signed [SAMPLE_WIDTH-1:0] left_sample,
    output logic signed [SAMPLE_WIDTH-1:0] right_sample
);

    logic [6:0]               key;
    logic [6:0]               velocity;
    logic                     gate;
    logic [6:0]               pan;
    logic [13:0]              bend;
    logic [15:0]              phase;
    logic                     note_start;
    logic                     note_release;
    logic signed [15:0]       bend_offset;
    logic signed [15:0]       bend_step;
    logic [15:0]              phase_inc;
    logic [15:0]              next_phase;
    logic [13:0]              left_prod;
    logic [13:0]              right_prod;
    logic [SAMPLE_WIDTH-2:0]  left_amp;
    logic [SAMPLE_WIDTH-2:0]  right_amp;

    // Square wave level is +amp or -amp, and silence with the gate closed.
    function automatic logic signed [SAMPLE_WIDTH-1:0] voice_level(
        input logic [SAMPLE_WIDTH-2:0] amp,
        input logic                    open,
        input logic                    negative
    );
        logic signed [SAMPLE_WIDTH-1:0] level;
        level = $signed({1'b0, amp});
        if (!open) begin
            return '0;
        end
        return negative ? -level : level;
    endfunction

    assign note_start = midi_rdy && (midi_cmd == MIDI_NOTE_ON) &&
                        (midi_payload.bytes.data1 != 7'd0);

    // Note on with zero velocity counts as note off.
    assign note_release = midi_rdy && (midi_payload.bytes.data0 == key) &&
                          ((midi_cmd == MIDI_NOTE_OFF) ||
                           ((midi_cmd == MIDI_NOTE_ON) && (midi_payload.bytes.data1 == 7'd0)));

    // Bend moves the step by -512..511.
    assign bend_offset = $signed({2'b00, bend}) - $signed({2'b00, MIDI_BEND_CENTRE});
    assign bend_step   = bend_offset >>> 4;
    assign phase_inc   = {3'b000, key, 6'b000000} + bend_step;
    assign next_phase  = phase + phase_inc;

    assign left_prod  = velocity * (7'd127 - pan);
    assign right_prod = velocity * pan;
    assign left_amp   = {left_prod, 3'b000};
    assign right_amp  = {right_prod, 3'b000};

    always_ff @(posedge clk) begin
        if (reset) begin
            key      <= 7'd0;
            velocity <= 7'd0;
            gate     <= 1'b0;
            pan      <= 7'd64;
            bend     <= MIDI_BEND_CENTRE;
        end else if (note_start) begin
            key      <= midi_payload.bytes.data0;
            velocity <= midi_payload.bytes.data1;
            gate     <= 1'b1;
        end else if (note_release) begin
            gate <= 1'b0;
        end else if (midi_rdy && (midi_cmd == MIDI_CTRL_CHANGE) &&
                     (midi_payload.bytes.data0 == MIDI_CC_PAN)) begin
            pan <= midi_payload.bytes.data1;
        end else if (midi_rdy && (midi_cmd == MIDI_PITCH_BEND)) begin
            bend <= midi_payload.bend;
        end
    end

    // Both channels of one sample pair use the advanced phase.
    always_ff @(posedge clk) begin
        if (reset) begin
            phase        <= 16'd0;
            left_sample  <= '0;
            right_sample <= '0;
        end else begin
            if (note_start) begin
                phase <= 16'd0;
            end else if (gen_left_sample) begin
                phase <= next_phase;
            end
            if (gen_left_sample) begin
                left_sample <= voice_level(left_amp, gate, next_phase[15]);
            end
            if (gen_right_sample) begin
                right_sample <= voice_level(right_amp, gate, phase[15]);
            end
        end
    end

endmodule

// ==== hdl/sample_ctrl.sv ====
/*
 * Audio sample-rate timer.
 * A free-running divider gives one left sample strobe every SAMPLE_DIV
 * clocks, followed by a right sample strobe in the next cycle.
 */

module sample_ctrl #(
    parameter int SAMPLE_DIV = 64
) (
    input  logic clk,
    input  logic reset,
    output logic gen_left_sample,
    output logic gen_right_sample
);

    localparam int CNT_W = $clog2(SAMPLE_DIV);

    logic [CNT_W-1:0] count;

    assign gen_left_sample = (count == CNT_W'(SAMPLE_DIV - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            count            <= '0;
            gen_right_sample <= 1'b0;
        end else begin
            count            <= gen_left_sample ? '0 : count + 1'b1;
            gen_right_sample <= gen_left_sample;
        end
    end

endmodule

// ==== hdl/midi_decoder.sv ====
/*
 * MIDI byte stream decoder.
 * Keeps the running status and collects the data bytes of one channel
 * message, then strobes midi_rdy with the command, channel and payload.
 * System common bytes clear the running status; real-time bytes are skipped.
 */

module midi_decoder import synth_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          data_received,
    input  logic [7:0]    data,
    output logic          midi_rdy,
    output logic [3:0]    midi_cmd,
    output logic [3:0]    midi_ch,
    output midi_payload_u midi_payload
);

    logic [7:0] running_status;
    logic       status_valid;
    logic       byte_count;
    logic [6:0] first_byte;
    logic       is_realtime;
    logic       is_system;
    logic       is_channel_status;
    logic       needs_one;
    logic       complete;

    // F8..FF real-time, F0..F7 system common and SysEx.
    assign is_realtime       = (data[7:3] == 5'b11111);
    assign is_system         = (data[7:3] == 5'b11110);
    assign is_channel_status = data[7] && (data[7:4] != 4'hF);

    assign needs_one = (running_status[7:4] == MIDI_PROG_CHANGE) ||
                       (running_status[7:4] == MIDI_CHAN_PRESSURE);

    // Last data byte of a message.
    assign complete = data_received && !data[7] && status_valid &&
                      (needs_one || byte_count);

    always_ff @(posedge clk) begin
        if (reset) begin
            status_valid <= 1'b0;
            byte_count   <= 1'b0;
            midi_rdy     <= 1'b0;
        end else begin
            midi_rdy <= complete;
            if (data_received && !is_realtime) begin
                if (is_system) begin
                    status_valid <= 1'b0;
                    byte_count   <= 1'b0;
                end else if (is_channel_status) begin
                    status_valid <= 1'b1;
                    byte_count   <= 1'b0;
                end else if (status_valid) begin
                    // Counter wraps so the next message reuses the status.
                    byte_count <= complete ? 1'b0 : 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_received && is_channel_status) begin
            running_status <= data;
        end
        if (data_received && !data[7] && !byte_count) begin
            first_byte <= data[6:0];
        end
        if (complete) begin
            midi_cmd <= running_status[7:4];
            midi_ch  <= running_status[3:0];
            if (needs_one) begin
                midi_payload.bytes.data0 <= data[6:0];
                midi_payload.bytes.data1 <= 7'd0;
            end else begin
                midi_payload.bytes.data0 <= first_byte;
                midi_payload.bytes.data1 <= data[6:0];
            end
        end
    end

endmodule

// ==== hdl/uart_rx.sv ====
/*
 * 8N1 serial receiver for the MIDI input line.
 * The line is idle high. Each bit lasts CLKS_PER_BIT clocks and is
 * sampled in its middle. A one-cycle data_received strobe marks a byte
 * with a good stop bit; frames with a low stop bit are dropped.
 */

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic       data_received,
    output logic [7:0] data
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT) + 1;
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_START = 2'd1;
    localparam logic [1:0] ST_DATA  = 2'd2;
    localparam logic [1:0] ST_STOP  = 2'd3;

    logic             rx_meta;
    logic             rx_sync;
    logic [1:0]       state;
    logic [CNT_W-1:0] bit_timer;
    logic [2:0]       bit_index;
    logic [7:0]       shift_reg;

    // Two-flop synchronizer that leaves reset at the idle level.
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= ST_IDLE;
            bit_timer     <= '0;
            bit_index     <= '0;
            data_received <= 1'b0;
        end else begin
            data_received <= 1'b0;
            case (state)
                ST_IDLE: begin
                    bit_timer <= '0;
                    if (!rx_sync) begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    // Glitch check at half a bit.
                    if (bit_timer == HALF_BIT) begin
                        bit_timer <= '0;
                        bit_index <= '0;
                        state     <= rx_sync ? ST_IDLE : ST_DATA;
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                ST_DATA: begin
                    if (bit_timer == FULL_BIT) begin
                        bit_timer <= '0;
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == 3'd7) begin
                            state <= ST_STOP;
                        end
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                default: begin
                    if (bit_timer == FULL_BIT) begin
                        state         <= ST_IDLE;
                        data_received <= rx_sync;
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB first.
    always_ff @(posedge clk) begin
        if (state == ST_DATA && bit_timer == FULL_BIT) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

    assign data = shift_reg;

endmodule

// ==== hdl/synth_pkg.sv ====
/*
 * Shared definitions for the MIDI pulse synthesizer.
 * Holds the sample width, the MIDI command codes and the payload union
 * that carries the data bytes of one channel message. Modules take what
 * they need with a wildcard import in their header.
 */

package synth_pkg;

    // Signed audio sample width.
    parameter int SAMPLE_WIDTH = 18;

    // Channel message commands, upper nibble of the status byte.
    parameter logic [3:0] MIDI_NOTE_OFF      = 4'd8;
    parameter logic [3:0] MIDI_NOTE_ON       = 4'd9;
    parameter logic [3:0] MIDI_CTRL_CHANGE   = 4'd11;
    parameter logic [3:0] MIDI_PROG_CHANGE   = 4'd12;
    parameter logic [3:0] MIDI_CHAN_PRESSURE = 4'd13;
    parameter logic [3:0] MIDI_PITCH_BEND    = 4'd14;

    // Pan controller number.
    parameter logic [6:0] MIDI_CC_PAN = 7'd10;

    // Centre value of the 14-bit pitch bend.
    parameter logic [13:0] MIDI_BEND_CENTRE = 14'd8192;

    // First data byte in data0, second in data1.
    // Key and velocity, or controller and value.
    typedef struct packed {
        logic [6:0] data1;
        logic [6:0] data0;
    } midi_bytes_t;

    // Pitch bend sends LSB first, so the bend view is {data1, data0}.
    typedef union packed {
        midi_bytes_t bytes;
        logic [13:0] bend;
    } midi_payload_u;

endpackage
